//--- include/pool_regs.svh
// Register word addresses and RESULT status bits, shared by the bus slave and the testbench
`ifndef POOL_REGS_SVH
`define POOL_REGS_SVH

// Word addresses on the 2-bit Wishbone address bus
`define REG_CTRL   2'd0
`define REG_COUNT  2'd1
`define REG_DATA   2'd2
`define REG_RESULT 2'd3

// Status bits returned with a RESULT read
`define STAT_BUSY  16
`define STAT_DONE  17

`endif

//--- src/pool_cfg_pkg.sv
// Datapath width defaults for the average-pooling unit, picked up by the top level
package pool_cfg_pkg;

    // Signed sample and result width
    localparam int DATA_W = 16;

    // Running sum and dividend width
    localparam int ACC_W = 32;

    // Window count width, N from 1 to 1023
    localparam int CNT_W = 10;

endpackage

//--- src/pool_ctrl_pkg.sv
// Control state encoding shared by the sequencing FSM and the bus slave
package pool_ctrl_pkg;

    // Window sequence
    //   ST_IDLE  waiting for the first start
    //   ST_ACC   taking samples
    //   ST_DIV   divider running
    //   ST_DONE  result valid, doubles as the done flag
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ACC  = 2'd1,
        ST_DIV  = 2'd2,
        ST_DONE = 2'd3
    } pool_state_t;

endpackage

//--- src/pool_fsm.sv
// Sequencer of the pooling window, from start through accumulate and divide to done
`timescale 1ns/1ns

module pool_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    input  logic                        last,
    input  logic                        div_done,
    output pool_ctrl_pkg::pool_state_t state,
    output logic                        clear,
    output logic                        load,
    output logic                        div_start
);
    import pool_ctrl_pkg::*;

    pool_state_t state_next;
    logic        go;

    // Start only counts when no window is in flight
    assign go = start && (state == ST_IDLE || state == ST_DONE);

    // New window: zero the sum and load N in the same cycle
    assign clear = go;
    assign load  = go;

    //////////////////////////////
    // Next state
    //////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (go) begin
                    state_next = ST_ACC;
                end
            end
            ST_ACC: begin
                // Final sample lands on the same edge as the move to divide
                if (last) begin
                    state_next = ST_DIV;
                end
            end
            ST_DIV: begin
                if (div_done) begin
                    state_next = ST_DONE;
                end
            end
            ST_DONE: begin
                if (go) begin
                    state_next = ST_ACC;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    //////////////////////////////
    // State register
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            div_start <= 1'b0;
        end else begin
            state     <= state_next;
            // One pulse in the first ST_DIV cycle, when the sum is final
            div_start <= (state_next == ST_DIV) && (state != ST_DIV);
        end
    end

    // Divider completion outside ST_DIV means the two blocks lost step
    a_div_done_in_div : assert property (
        @(posedge clk) disable iff (rst) div_done |-> state == ST_DIV
    );

endmodule

//--- src/sample_counter.sv
// Down-counter of the samples still owed to the current window, flags the last one
`timescale 1ns/1ns

module sample_counter #(
    parameter int cnt_w = pool_cfg_pkg::CNT_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             load,
    input  logic             dec,
    input  logic [cnt_w-1:0] count_in,
    output logic             last
);

    logic [cnt_w-1:0] remaining;

    // High only while the final sample is being accepted
    assign last = dec && (remaining == cnt_w'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            remaining <= '0;
        end else if (load) begin
            remaining <= count_in;
        end else if (dec) begin
            remaining <= remaining - cnt_w'(1);
        end
    end

    // A sample past the end of the window, or a window started with N of zero
    a_no_dec_at_zero : assert property (
        @(posedge clk) disable iff (rst) dec |-> remaining != '0
    );

endmodule

//--- src/pool_accum.sv
// Signed running sum of the window's samples, cleared at the start of each window
`timescale 1ns/1ns

module pool_accum #(
    parameter int data_w = pool_cfg_pkg::DATA_W,
    parameter int acc_w  = pool_cfg_pkg::ACC_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear,
    input  logic              add,
    input  logic [data_w-1:0] sample,
    output logic [acc_w-1:0]  sum
);

    logic [acc_w-1:0] sample_ext;

    // Sign extension up to the accumulator width
    assign sample_ext = {{(acc_w - data_w){sample[data_w-1]}}, sample};

    //////////////////////////////
    // Sum register
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else if (add) begin
            // 1023 full-scale samples stay well inside 32 bits
            sum <= sum + sample_ext;
        end
    end

endmodule

//--- src/pool_divider.sv
// Sequential signed restoring divider, sum over N with the quotient truncated toward zero
`timescale 1ns/1ns

module pool_divider #(
    parameter int data_w = pool_cfg_pkg::DATA_W,
    parameter int acc_w  = pool_cfg_pkg::ACC_W,
    parameter int cnt_w  = pool_cfg_pkg::CNT_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [acc_w-1:0]  dividend,
    input  logic [cnt_w-1:0]  divisor,
    output logic              done,
    output logic [data_w-1:0] quotient
);
    localparam int step_w = $clog2(acc_w + 1);

    logic              busy;
    logic [step_w-1:0] step;
    logic              neg;
    logic [cnt_w-1:0]  dvs;
    logic [cnt_w-1:0]  rem;
    logic [acc_w-1:0]  quo;
    logic [cnt_w:0]    rem_sh;
    logic [cnt_w+1:0]  diff;
    logic              fits;
    logic [cnt_w-1:0]  rem_next;
    logic [acc_w-1:0]  quo_next;

    // One restoring step, quo shifts out dividend bits and takes quotient bits in
    always_comb begin
        rem_sh   = {rem, quo[acc_w-1]};
        diff     = {1'b0, rem_sh} - {2'b00, dvs};
        fits     = !diff[cnt_w+1];
        rem_next = fits ? diff[cnt_w-1:0] : rem_sh[cnt_w-1:0];
        quo_next = {quo[acc_w-2:0], fits};
    end

    //////////////////////////////
    // Step control
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            step     <= '0;
            done     <= 1'b0;
            quotient <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= step_w'(acc_w);
            end else if (busy) begin
                step <= step - step_w'(1);
                if (step == step_w'(1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    // Sign restored on the magnitude quotient, so rounding is toward zero
                    quotient <= neg ? -quo_next[data_w-1:0] : quo_next[data_w-1:0];
                end
            end
        end
    end

    // Operands, captured at start so a COUNT write mid-divide does no harm
    always_ff @(posedge clk) begin
        if (start) begin
            neg <= dividend[acc_w-1];
            dvs <= divisor;
            rem <= '0;
            quo <= dividend[acc_w-1] ? -dividend : dividend;
        end else if (busy) begin
            rem <= rem_next;
            quo <= quo_next;
        end
    end

    a_no_zero_divisor : assert property (
        @(posedge clk) disable iff (rst) start |-> divisor != '0
    );

endmodule

//--- src/pool_wb_regs.sv
// Wishbone classic slave for COUNT, CTRL, DATA and RESULT, with DATA stalled during divide
`timescale 1ns/1ns

module pool_wb_regs #(
    parameter int data_w = pool_cfg_pkg::DATA_W,
    parameter int cnt_w  = pool_cfg_pkg::CNT_W
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [1:0]                  wb_adr,
    input  logic [31:0]                 wb_dat_i,
    output logic [31:0]                 wb_dat_o,
    output logic                        wb_ack,
    input  pool_ctrl_pkg::pool_state_t  state,
    input  logic [data_w-1:0]           quotient,
    output logic [cnt_w-1:0]            count,
    output logic                        start,
    output logic                        sample_valid,
    output logic [data_w-1:0]           sample
);
    import pool_ctrl_pkg::*;
    `include "pool_regs.svh"

    logic              bus_req;
    logic              data_wr;
    logic              hold;
    logic              accept;
    logic              busy;
    logic              done;
    logic [data_w-1:0] result_q;
    logic [15:0]       result_ext;
    logic [31:0]       rd_data;

    //////////////////////////////
    // Bus decode
    //////////////////////////////
    // No new cycle is taken while ack is out
    assign bus_req = wb_cyc && wb_stb && !wb_ack;
    assign data_wr = bus_req && wb_we && (wb_adr == `REG_DATA);
    // DATA is the only register that waits out the divider
    assign hold    = data_wr && (state == ST_DIV);
    assign accept  = bus_req && !hold;

    // Samples reach the datapath only in ST_ACC
    assign sample_valid = data_wr && (state == ST_ACC);
    assign sample       = wb_dat_i[data_w-1:0];

    assign busy       = (state == ST_ACC) || (state == ST_DIV);
    assign done       = (state == ST_DONE);
    assign result_ext = 16'($signed(result_q));

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `REG_COUNT: rd_data[cnt_w-1:0] = count;
            `REG_RESULT: begin
                rd_data[15:0]       = result_ext;
                rd_data[`STAT_BUSY] = busy;
                rd_data[`STAT_DONE] = done;
            end
            default: rd_data = '0;
        endcase
    end

    //////////////////////////////
    // Registers
    //////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wb_dat_o <= '0;
            start    <= 1'b0;
            count    <= cnt_w'(1);
            result_q <= '0;
        end else begin
            wb_ack <= accept;
            start  <= accept && wb_we && (wb_adr == `REG_CTRL) && wb_dat_i[0] && !busy;
            if (accept && !wb_we) begin
                wb_dat_o <= rd_data;
            end
            if (accept && wb_we && (wb_adr == `REG_COUNT)) begin
                count <= wb_dat_i[cnt_w-1:0];
            end
            // Divider output is final in the last ST_DIV cycle, so this lands on entry to ST_DONE
            if (state == ST_DIV) begin
                result_q <= quotient;
            end
        end
    end

    // Master keeps the request steady until it sees the ack
    a_req_held : assert property (
        @(posedge clk) disable iff (rst)
        bus_req |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we)
    );

endmodule

//--- src/avg_pool_top.sv
// Average-pooling unit top level, Wishbone slave in front of the FSM, counter and datapath
`timescale 1ns/1ns

module avg_pool_top #(
    parameter int data_w = pool_cfg_pkg::DATA_W,
    parameter int acc_w  = pool_cfg_pkg::ACC_W,
    parameter int cnt_w  = pool_cfg_pkg::CNT_W
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack,
    output logic        irq
);
    import pool_ctrl_pkg::*;

    pool_state_t       state;
    logic              start;
    logic              sample_valid;
    logic [data_w-1:0] sample;
    logic [cnt_w-1:0]  count;
    logic              last;
    logic              clear;
    logic              load;
    logic [acc_w-1:0]  sum;
    logic              div_start;
    logic              div_done;
    logic [data_w-1:0] quotient;

    // Interrupt is the done flag itself
    assign irq = (state == ST_DONE);

    pool_wb_regs #(.data_w(data_w), .cnt_w(cnt_w)) pool_wb_regs_inst (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
        .state(state), .quotient(quotient), .count(count),
        .start(start), .sample_valid(sample_valid), .sample(sample)
    );

    pool_fsm pool_fsm_inst (
        .clk(clk), .rst(rst), .start(start), .last(last), .div_done(div_done),
        .state(state), .clear(clear), .load(load), .div_start(div_start)
    );

    sample_counter #(.cnt_w(cnt_w)) sample_counter_inst (
        .clk(clk), .rst(rst), .load(load), .dec(sample_valid),
        .count_in(count), .last(last)
    );

    pool_accum #(.data_w(data_w), .acc_w(acc_w)) pool_accum_inst (
        .clk(clk), .rst(rst), .clear(clear), .add(sample_valid),
        .sample(sample), .sum(sum)
    );

    pool_divider #(.data_w(data_w), .acc_w(acc_w), .cnt_w(cnt_w)) pool_divider_inst (
        .clk(clk), .rst(rst), .start(div_start), .dividend(sum), .divisor(count),
        .done(div_done), .quotient(quotient)
    );

endmodule

//--- sim/avg_pool_tb.sv
// Testbench for the average-pooling unit, runs windows over Wishbone and checks each average
`timescale 1ns/1ns
`include "pool_regs.svh"

module avg_pool_tb;
    import pool_cfg_pkg::*;

    typedef logic signed [15:0] sample_q_t[$];

    // Window sizes of the tests
    localparam int n_idle    = 6;
    localparam int n_rand    = 9;
    localparam int n_neg     = 5;
    localparam int n_one     = 1;
    localparam int n_big     = 1023;
    localparam int n_late    = 9;
    localparam int n_windows = 6;
    // Four cycles per sample, the divide plus slack per window, and a margin
    localparam int max_cycles = (n_idle + n_rand + n_neg + n_one + n_big + n_late) * 4
                              + n_windows * (ACC_W + 40) + 200;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack;
    logic        irq;

    int seed = 32'h2f7f;
    int cycles;
    int errors;
    int tests;
    int tests_failed;
    // Expected averages, oldest first
    int exp_q[$];

    avg_pool_top #(.data_w(DATA_W), .acc_w(ACC_W), .cnt_w(CNT_W)) avg_pool_top_inst (
        .clk(clk), .rst(rst),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack), .irq(irq)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic int avg_ref(input sample_q_t s);
        int sum;
        sum = 0;
        foreach (s[i]) begin
            sum += int'(s[i]);
        end
        // Signed int division truncates toward zero
        return sum / s.size();
    endfunction

    function automatic sample_q_t random_samples(input int n);
        sample_q_t s;
        for (int i = 0; i < n; i++) begin
            s.push_back(16'($random(seed)));
        end
        return s;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("Error at %0t ns: %s expected %0d actual %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    //////////////////////////////
    // Bus master
    //////////////////////////////
    task automatic bus_xfer(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output int waited, output logic irq_seen);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_i <= wdata;
        waited = 0;
        @(negedge clk);
        while (!wb_ack) begin
            waited++;
            @(negedge clk);
        end
        rdata    = wb_dat_o;
        irq_seen = irq;
        // Bus released in the cycle after ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] wdata);
        logic [31:0] rdata;
        int          waited;
        logic        irq_seen;
        bus_xfer(1'b1, adr, wdata, rdata, waited, irq_seen);
    endtask

    task automatic bus_read(input logic [1:0] adr, output logic [31:0] rdata);
        int   waited;
        logic irq_seen;
        bus_xfer(1'b0, adr, 32'h0, rdata, waited, irq_seen);
    endtask

    // Start a window of s.size() samples, busy must show once it is open
    task automatic run_window(input sample_q_t s);
        logic [31:0] rdata;
        bus_write(`REG_COUNT, 32'(s.size()));
        bus_write(`REG_CTRL, 32'h1);
        bus_read(`REG_RESULT, rdata);
        check_value("busy", 1, int'(rdata[`STAT_BUSY]));
        foreach (s[i]) begin
            bus_write(`REG_DATA, {16'h0000, s[i]});
        end
        exp_q.push_back(avg_ref(s));
    endtask

    task automatic wait_done(output logic irq_seen);
        logic [31:0] rdata;
        int          waited;
        rdata = '0;
        while (!rdata[`STAT_DONE]) begin
            bus_xfer(1'b0, `REG_RESULT, 32'h0, rdata, waited, irq_seen);
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed", name);
        end
    endtask

    //////////////////////////////
    // Checker and timeout
    //////////////////////////////
    // Every RESULT read that returns done is held against the oldest expected average
    always @(negedge clk) begin
        if (wb_ack && !wb_we && wb_adr == `REG_RESULT && wb_dat_o[`STAT_DONE]
            && exp_q.size() != 0) begin
            check_value("result", exp_q.pop_front(), int'($signed(wb_dat_o[15:0])));
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        sample_q_t   s;
        logic [31:0] rdata;
        logic        irq_seen;
        int          waited;
        int          err0;
        clk          = 1'b0;
        rst          = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = 2'd0;
        wb_dat_i     = 32'h0;
        cycles       = 0;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        err0 = errors;
        bus_xfer(1'b0, `REG_RESULT, 32'h0, rdata, waited, irq_seen);
        check_value("busy", 0, int'(rdata[`STAT_BUSY]));
        check_value("done", 0, int'(rdata[`STAT_DONE]));
        check_value("result", 0, int'(rdata[15:0]));
        check_value("irq", 0, int'(irq_seen));
        bus_read(`REG_COUNT, rdata);
        check_value("count", 1, int'(rdata));
        end_test("reset values", err0);

        // Still in ST_IDLE, these samples must be dropped
        err0 = errors;
        repeat (3) begin
            bus_xfer(1'b1, `REG_DATA, 32'($random(seed)), rdata, waited, irq_seen);
            check_value("ack_wait", 1, waited);
        end
        s = random_samples(n_idle);
        run_window(s);
        wait_done(irq_seen);
        end_test("data writes in idle", err0);

        err0 = errors;
        s = random_samples(n_rand);
        run_window(s);
        wait_done(irq_seen);
        check_value("irq", 1, int'(irq_seen));
        end_test("random window of 9", err0);

        // Sum -23 over 5, toward zero is -4 where floor would be -5
        err0 = errors;
        s = '{-16'sd3, -16'sd7, -16'sd2, -16'sd10, -16'sd1};
        run_window(s);
        wait_done(irq_seen);
        end_test("negative uneven window", err0);

        err0 = errors;
        s = '{-16'sd12345};
        run_window(s);
        wait_done(irq_seen);
        end_test("window of 1", err0);

        err0 = errors;
        s = random_samples(n_big);
        run_window(s);
        wait_done(irq_seen);
        end_test("random window of 1023", err0);

        // Final sample already taken, this write stalls behind the divider
        err0 = errors;
        s = random_samples(n_late);
        run_window(s);
        bus_xfer(1'b1, `REG_DATA, 32'h0000_7fff, rdata, waited, irq_seen);
        check_value("irq", 1, int'(irq_seen));
        wait_done(irq_seen);
        end_test("data write during divide", err0);

        if (exp_q.size() != 0) begin
            $display("%0d window results were never read back", exp_q.size());
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- pool_avg.f
+incdir+include
src/pool_cfg_pkg.sv
src/pool_ctrl_pkg.sv
src/pool_fsm.sv
src/sample_counter.sv
src/pool_accum.sv
src/pool_divider.sv
src/pool_wb_regs.sv
src/avg_pool_top.sv
sim/avg_pool_tb.sv

//--- Makefile
TOP := avg_pool_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make help   list these targets"
	@echo "make test   build with Verilator, run the testbench, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module $(TOP) -f pool_avg.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
